//--- verilog.f
hw/dmem_pkg.sv
hw/data_memory.sv
hw/mem_arbiter.sv
hw/load_store_unit.sv
hw/block_copy_engine.sv
hw/mem_subsystem_top.sv
tb/mem_subsystem_assertions.sv
tb/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and decide by searching the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem \
    -f verilog.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation stopped early, see build.log and sim.log"
grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem import dmem_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;  // cycles per wait loop

    logic                     clk;
    logic                     rst;
    logic                     ls_req;
    logic                     ls_write_en;
    logic [1:0]               ls_size;
    logic                     ls_unsigned;
    logic [ADDR_LEN-1:0]      ls_addr;
    logic [WORD_LEN-1:0]      ls_wdata;
    logic                     ls_ack;
    logic [WORD_LEN-1:0]      ls_rdata;
    logic                     ls_misaligned;
    logic                     copy_start;
    logic [WORD_ADDR_LEN-1:0] copy_src;
    logic [WORD_ADDR_LEN-1:0] copy_dst;
    logic [COPY_LEN_W-1:0]    copy_len;
    logic                     copy_busy;
    logic                     copy_done;

    logic [7:0] ref_mem [1024];  // byte-wide reference model
    int         errors;
    int         errors_at_start;
    int         checks;
    int         tests_done;
    int         tests_failed;

    mem_subsystem_top UUT (
        .i_clk           (clk),
        .i_rst           (rst),
        .i_ls_req        (ls_req),
        .i_ls_write_en   (ls_write_en),
        .i_ls_size       (ls_size),
        .i_ls_unsigned   (ls_unsigned),
        .i_ls_addr       (ls_addr),
        .i_ls_wdata      (ls_wdata),
        .o_ls_ack        (ls_ack),
        .o_ls_rdata      (ls_rdata),
        .o_ls_misaligned (ls_misaligned),
        .i_copy_start    (copy_start),
        .i_copy_src      (copy_src),
        .i_copy_dst      (copy_dst),
        .i_copy_len      (copy_len),
        .o_copy_busy     (copy_busy),
        .o_copy_done     (copy_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void model_reset();
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;
        end
        ref_mem[0] = 8'h11;
        ref_mem[1] = 8'h22;
        ref_mem[2] = 8'h33;
        ref_mem[3] = 8'h44;
    endfunction

    function automatic void model_store(input int a, input logic [1:0] size,
                                        input logic [WORD_LEN-1:0] data);
        ref_mem[a] = data[7:0];
        if (size != SIZE_BYTE) begin
            ref_mem[a + 1] = data[15:8];
        end
        if (size == SIZE_WORD) begin
            ref_mem[a + 2] = data[23:16];
            ref_mem[a + 3] = data[31:24];
        end
    endfunction

    // little endian, sign taken from the top bit of the selected data
    function automatic logic [WORD_LEN-1:0] expected_load(input int a, input logic [1:0] size,
                                                          input logic uns);
        logic [7:0]          b;
        logic [15:0]         h;
        logic [WORD_LEN-1:0] value;
        b = ref_mem[a];
        h = {ref_mem[(a + 1) % 1024], ref_mem[a]};
        case (size)
            SIZE_BYTE: value = (b[7] && !uns) ? {24'hff_ffff, b} : {24'h00_0000, b};
            SIZE_HALF: value = (h[15] && !uns) ? {16'hffff, h} : {16'h0000, h};
            default:   value = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
        return value;
    endfunction

    task automatic check_value(input string name, input logic [WORD_LEN-1:0] got,
                               input logic [WORD_LEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run();
        int total;
        total = errors + int'(UUT.u_sva.fail_count);
        $display("tests %0d, tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_done, tests_failed, checks, errors, UUT.u_sva.fail_count);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("timeout while waiting for %s at %0t", what, $time);
        finish_run();
    endtask

    task automatic end_test(input string name);
        tests_done++;
        if (errors == errors_at_start) begin
            $display("test %0d %s ok", tests_done, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_done, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // one full four-phase transaction on the load/store port
    task automatic ls_access(input logic we, input logic [1:0] size, input logic uns,
                             input int a, input logic [WORD_LEN-1:0] wdata,
                             output logic [WORD_LEN-1:0] rdata, output logic mis);
        int n;
        @(posedge clk);
        ls_req      <= 1'b1;
        ls_write_en <= we;
        ls_size     <= size;
        ls_unsigned <= uns;
        ls_addr     <= ADDR_LEN'(a);
        ls_wdata    <= wdata;
        n = 0;
        @(negedge clk);
        while (!ls_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ls_ack) begin
            timeout_abort("o_ls_ack to rise");
        end
        rdata = ls_rdata;
        mis   = ls_misaligned;
        @(posedge clk);
        ls_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (ls_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ls_ack) begin
            timeout_abort("o_ls_ack to fall");
        end
    endtask

    task automatic store_check(input int a, input logic [1:0] size,
                               input logic [WORD_LEN-1:0] data);
        logic [WORD_LEN-1:0] rd;
        logic                mis;
        ls_access(1'b1, size, 1'b0, a, data, rd, mis);
        check_value("o_ls_misaligned", {31'b0, mis}, 32'h0);
        model_store(a, size, data);
    endtask

    task automatic load_check(input int a, input logic [1:0] size, input logic uns);
        logic [WORD_LEN-1:0] rd;
        logic                mis;
        ls_access(1'b0, size, uns, a, '0, rd, mis);
        check_value("o_ls_misaligned", {31'b0, mis}, 32'h0);
        check_value("o_ls_rdata", rd, expected_load(a, size, uns));
    endtask

    task automatic refused_check(input logic we, input logic [1:0] size, input int a);
        logic [WORD_LEN-1:0] rd;
        logic                mis;
        ls_access(we, size, 1'b0, a, 32'hdead_beef, rd, mis);
        check_value("o_ls_misaligned", {31'b0, mis}, 32'h1);
    endtask

    task automatic fill_random_words(input int first_word, input int count);
        for (int w = first_word; w < first_word + count; w++) begin
            store_check(4 * w, SIZE_WORD, $urandom());
        end
    endtask

    task automatic copy_run(input int src, input int dst, input int len);
        int n;
        @(posedge clk);
        copy_start <= 1'b1;
        copy_src   <= WORD_ADDR_LEN'(src);
        copy_dst   <= WORD_ADDR_LEN'(dst);
        copy_len   <= COPY_LEN_W'(len);
        @(posedge clk);
        copy_start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!copy_done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!copy_done) begin
            timeout_abort("o_copy_done");
        end
        for (int i = 0; i < 4 * len; i++) begin
            ref_mem[4 * dst + i] = ref_mem[4 * src + i];
        end
    endtask

    task automatic wait_copy_busy();
        int n;
        n = 0;
        @(negedge clk);
        while (!copy_busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!copy_busy) begin
            timeout_abort("o_copy_busy");
        end
    endtask

    task automatic compare_words(input int first_word, input int count);
        for (int w = first_word; w < first_word + count; w++) begin
            load_check(4 * w, SIZE_WORD, 1'b0);
        end
    endtask

    initial begin
        logic [WORD_LEN-1:0] rd;
        logic                mis;
        logic [31:0]         rnd;
        logic [ADDR_LEN-1:0] a;
        logic [1:0]          sz;
        rst         = 1'b1;
        ls_req      = 1'b0;
        ls_write_en = 1'b0;
        ls_size     = SIZE_WORD;
        ls_unsigned = 1'b0;
        ls_addr     = '0;
        ls_wdata    = '0;
        copy_start  = 1'b0;
        copy_src    = '0;
        copy_dst    = '0;
        copy_len    = '0;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests_done      = 0;
        tests_failed    = 0;
        rnd = $urandom(32'hd01a_e5c3);  // seed once
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        ls_access(1'b0, SIZE_WORD, 1'b0, 0, '0, rd, mis);
        check_value("o_ls_rdata", rd, 32'h4433_2211);
        ls_access(1'b0, SIZE_BYTE, 1'b0, 3, '0, rd, mis);
        check_value("o_ls_rdata", rd, 32'h0000_0044);
        ls_access(1'b0, SIZE_HALF, 1'b0, 2, '0, rd, mis);
        check_value("o_ls_rdata", rd, 32'h0000_4433);
        end_test("preload");

        store_check('h40, SIZE_BYTE, 32'h0000_0080);  // top bit set
        store_check('h41, SIZE_BYTE, 32'h0000_00f0);
        store_check('h42, SIZE_HALF, 32'h0000_8001);
        store_check('h44, SIZE_WORD, 32'hf07f_8001);
        store_check('h48, SIZE_WORD, 32'h1234_5678);
        store_check('h49, SIZE_BYTE, 32'h0000_00c3);
        store_check('h4a, SIZE_HALF, 32'h0000_7ffe);
        for (int ad = 'h40; ad < 'h4c; ad++) begin
            for (int s = 0; s < 3; s++) begin
                if (ad % (1 << s) == 0) begin
                    load_check(ad, 2'(s), 1'b0);
                    load_check(ad, 2'(s), 1'b1);
                end
            end
        end
        end_test("sub-word stores and loads");

        store_check('h50, SIZE_WORD, 32'hcafe_f00d);
        refused_check(1'b1, SIZE_HALF, 'h51);
        refused_check(1'b1, SIZE_WORD, 'h52);
        refused_check(1'b1, 2'b11, 'h50);
        refused_check(1'b0, SIZE_WORD, 'h53);
        refused_check(1'b0, SIZE_HALF, 'h53);
        load_check('h50, SIZE_WORD, 1'b0);  // memory left as it was
        end_test("misaligned refused");

        fill_random_words(64, 8);
        copy_run(64, 96, 8);
        compare_words(64, 8);
        compare_words(96, 8);
        end_test("block copy");

        fill_random_words(128, 8);
        fork
            copy_run(128, 160, 8);
            begin
                wait_copy_busy();
                for (int i = 0; i < 4; i++) begin
                    store_check('h320 + 4 * i, SIZE_WORD, $urandom());
                    load_check('h321 + 4 * i, SIZE_BYTE, 1'(i));
                end
            end
        join
        compare_words(160, 8);
        compare_words(200, 4);
        end_test("copy under contention");

        for (int i = 0; i < 200; i++) begin
            rnd = $urandom();
            sz  = (rnd[1:0] == 2'b11) ? SIZE_WORD : rnd[1:0];
            a   = rnd[11:2];
            if (sz == SIZE_HALF) begin
                a[0] = 1'b0;
            end else if (sz == SIZE_WORD) begin
                a[1:0] = 2'b00;
            end
            if (rnd[12]) begin
                store_check(int'(a), sz, $urandom());
            end else begin
                load_check(int'(a), sz, rnd[13]);
            end
        end
        end_test("random mixed accesses");

        finish_run();
    end

endmodule

//--- tb/mem_subsystem_assertions.sv
`timescale 1ns/1ns

module mem_subsystem_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic i_ls_req,
    input logic i_ls_ack,
    input logic i_m0_req,
    input logic i_m0_ack,
    input logic i_m1_req,
    input logic i_m1_ack,
    input logic i_mem_en,
    input logic i_copy_busy,
    input logic i_copy_done
);

    int unsigned fail_count = 0;  // failed assertions so far

    // four-phase rule on the external load/store port
    ls_ack_rise: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_ls_ack) |-> i_ls_req)
        else begin
            fail_count++;
            $error("o_ls_ack rose while i_ls_req was low");
        end

    ls_ack_fall: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_ls_ack) |-> !$past(i_ls_req))
        else begin
            fail_count++;
            $error("o_ls_ack fell before i_ls_req had fallen");
        end

    // an arbiter ack only opens for a master that is requesting
    m0_grant: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_m0_ack) |-> i_m0_req)
        else begin
            fail_count++;
            $error("arbiter acked the load/store unit without a request");
        end

    m1_grant: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_m1_ack) |-> i_m1_req)
        else begin
            fail_count++;
            $error("arbiter acked the copy engine without a request");
        end

    m0_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
        i_m0_req && !i_m0_ack |=> i_m0_req)
        else begin
            fail_count++;
            $error("load/store unit dropped its request before the ack");
        end

    m1_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
        i_m1_req && !i_m1_ack |=> i_m1_req)
        else begin
            fail_count++;
            $error("copy engine dropped its request before the ack");
        end

    // done is a single pulse that closes the busy window
    done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_copy_done |=> !i_copy_done && !i_copy_busy)
        else begin
            fail_count++;
            $error("o_copy_done longer than one cycle or busy still high after it");
        end

    busy_end: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_copy_busy) |-> $past(i_copy_done))
        else begin
            fail_count++;
            $error("o_copy_busy fell without o_copy_done");
        end

    reset_quiet: assert property (@(posedge i_clk)
        $fell(i_rst) |-> !i_ls_ack && !i_m0_ack && !i_m1_ack && !i_copy_busy && !i_mem_en)
        else begin
            fail_count++;
            $error("acks, busy or memory enable high right after reset");
        end

endmodule

bind mem_subsystem_top mem_subsystem_assertions u_sva (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_ls_req    (i_ls_req),
    .i_ls_ack    (o_ls_ack),
    .i_m0_req    (m0_req),
    .i_m0_ack    (m0_ack),
    .i_m1_req    (m1_req),
    .i_m1_ack    (m1_ack),
    .i_mem_en    (mem_en),
    .i_copy_busy (o_copy_busy),
    .i_copy_done (o_copy_done)
);

//--- hw/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top import dmem_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    // load/store port
    input  logic                     i_ls_req,
    input  logic                     i_ls_write_en,
    input  logic [1:0]               i_ls_size,
    input  logic                     i_ls_unsigned,
    input  logic [ADDR_LEN-1:0]      i_ls_addr,
    input  logic [WORD_LEN-1:0]      i_ls_wdata,
    output logic                     o_ls_ack,
    output logic [WORD_LEN-1:0]      o_ls_rdata,
    output logic                     o_ls_misaligned,
    // copy port
    input  logic                     i_copy_start,
    input  logic [WORD_ADDR_LEN-1:0] i_copy_src,
    input  logic [WORD_ADDR_LEN-1:0] i_copy_dst,
    input  logic [COPY_LEN_W-1:0]    i_copy_len,
    output logic                     o_copy_busy,
    output logic                     o_copy_done
);

    // master 0, load/store unit
    logic                     m0_req;
    logic                     m0_we;
    logic [3:0]               m0_be;
    logic [WORD_ADDR_LEN-1:0] m0_waddr;
    logic [WORD_LEN-1:0]      m0_wdata;
    logic                     m0_ack;
    logic [WORD_LEN-1:0]      m0_rdata;
    // master 1, copy engine
    logic                     m1_req;
    logic                     m1_we;
    logic [3:0]               m1_be;
    logic [WORD_ADDR_LEN-1:0] m1_waddr;
    logic [WORD_LEN-1:0]      m1_wdata;
    logic                     m1_ack;
    logic [WORD_LEN-1:0]      m1_rdata;
    // arbiter to memory
    logic                     mem_en;
    logic                     mem_we;
    logic [3:0]               mem_be;
    logic [WORD_ADDR_LEN-1:0] mem_addr;
    logic [WORD_LEN-1:0]      mem_wdata;
    logic [WORD_LEN-1:0]      mem_rdata;

    load_store_unit u_lsu (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_ls_req),
        .i_write_en   (i_ls_write_en),
        .i_size       (i_ls_size),
        .i_unsigned   (i_ls_unsigned),
        .i_addr       (i_ls_addr),
        .i_wdata      (i_ls_wdata),
        .o_ack        (o_ls_ack),
        .o_rdata      (o_ls_rdata),
        .o_misaligned (o_ls_misaligned),
        .o_m_req      (m0_req),
        .o_m_we       (m0_we),
        .o_m_be       (m0_be),
        .o_m_addr     (m0_waddr),
        .o_m_wdata    (m0_wdata),
        .i_m_ack      (m0_ack),
        .i_m_rdata    (m0_rdata)
    );

    block_copy_engine u_copy (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (i_copy_start),
        .i_src     (i_copy_src),
        .i_dst     (i_copy_dst),
        .i_len     (i_copy_len),
        .o_busy    (o_copy_busy),
        .o_done    (o_copy_done),
        .o_m_req   (m1_req),
        .o_m_we    (m1_we),
        .o_m_be    (m1_be),
        .o_m_addr  (m1_waddr),
        .o_m_wdata (m1_wdata),
        .i_m_ack   (m1_ack),
        .i_m_rdata (m1_rdata)
    );

    mem_arbiter u_arb (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_m0_req    (m0_req),
        .i_m0_we     (m0_we),
        .i_m0_be     (m0_be),
        .i_m0_addr   (m0_waddr),
        .i_m0_wdata  (m0_wdata),
        .o_m0_ack    (m0_ack),
        .o_m0_rdata  (m0_rdata),
        .i_m1_req    (m1_req),
        .i_m1_we     (m1_we),
        .i_m1_be     (m1_be),
        .i_m1_addr   (m1_waddr),
        .i_m1_wdata  (m1_wdata),
        .o_m1_ack    (m1_ack),
        .o_m1_rdata  (m1_rdata),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_be    (mem_be),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    data_memory u_mem (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_be    (mem_be),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

//--- hw/block_copy_engine.sv
`timescale 1ns/1ns

module block_copy_engine import dmem_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_start,
    input  logic [WORD_ADDR_LEN-1:0] i_src,   // word index
    input  logic [WORD_ADDR_LEN-1:0] i_dst,
    input  logic [COPY_LEN_W-1:0]    i_len,   // words to move
    output logic                     o_busy,
    output logic                     o_done,
    // towards the arbiter
    output logic                     o_m_req,
    output logic                     o_m_we,
    output logic [3:0]               o_m_be,
    output logic [WORD_ADDR_LEN-1:0] o_m_addr,
    output logic [WORD_LEN-1:0]      o_m_wdata,
    input  logic                     i_m_ack,
    input  logic [WORD_LEN-1:0]      i_m_rdata
);

    logic [2:0]               state;
    logic [WORD_ADDR_LEN-1:0] src_q;
    logic [WORD_ADDR_LEN-1:0] dst_q;
    logic [COPY_LEN_W-1:0]    remain;
    logic [WORD_LEN-1:0]      word_q;  // word in flight

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= CPY_IDLE;
        end else begin
            case (state)
                CPY_IDLE: begin
                    if (i_start) begin
                        state <= (i_len == '0) ? CPY_DONE : CPY_RD;
                    end
                end
                CPY_RD: begin
                    if (i_m_ack) begin
                        state <= CPY_RD_REL;
                    end
                end
                CPY_RD_REL: begin
                    if (!i_m_ack) begin
                        state <= CPY_WR;
                    end
                end
                CPY_WR: begin
                    if (i_m_ack) begin
                        state <= CPY_WR_REL;
                    end
                end
                CPY_WR_REL: begin
                    if (!i_m_ack) begin
                        state <= (remain == 1) ? CPY_DONE : CPY_RD;
                    end
                end
                default: state <= CPY_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == CPY_IDLE && i_start) begin
            src_q  <= i_src;
            dst_q  <= i_dst;
            remain <= i_len;
        end else if (state == CPY_WR_REL && !i_m_ack) begin
            src_q  <= src_q + 1'b1;  // next word
            dst_q  <= dst_q + 1'b1;
            remain <= remain - 1'b1;
        end
        if (state == CPY_RD && i_m_ack) begin
            word_q <= i_m_rdata;
        end
    end

    assign o_busy    = (state != CPY_IDLE);
    assign o_done    = (state == CPY_DONE);
    assign o_m_req   = (state == CPY_RD) || (state == CPY_WR);
    assign o_m_we    = (state == CPY_WR);
    assign o_m_be    = {4{o_m_we}};            // whole word on writes
    assign o_m_addr  = o_m_we ? dst_q : src_q;
    assign o_m_wdata = word_q;

endmodule

//--- hw/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit import dmem_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_req,
    input  logic                     i_write_en,
    input  logic [1:0]               i_size,      // 00 byte, 01 half, 10 word
    input  logic                     i_unsigned,
    input  logic [ADDR_LEN-1:0]      i_addr,      // byte address
    input  logic [WORD_LEN-1:0]      i_wdata,
    output logic                     o_ack,
    output logic [WORD_LEN-1:0]      o_rdata,
    output logic                     o_misaligned,
    // towards the arbiter
    output logic                     o_m_req,
    output logic                     o_m_we,
    output logic [3:0]               o_m_be,
    output logic [WORD_ADDR_LEN-1:0] o_m_addr,
    output logic [WORD_LEN-1:0]      o_m_wdata,
    input  logic                     i_m_ack,
    input  logic [WORD_LEN-1:0]      i_m_rdata
);

    logic [1:0]          state;
    logic [1:0]          lane;
    logic                misaligned;
    lane_word_u          st_word;
    logic [3:0]          st_be;
    lane_word_u          ld_word;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    logic                ld_sign;
    logic [WORD_LEN-1:0] ld_value;

    assign lane = i_addr[1:0];

    always_comb begin
        case (i_size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = lane[0];
            SIZE_WORD: misaligned = |lane;
            default:   misaligned = 1'b1;  // size 11 refused
        endcase
    end

    // store lane placement
    always_comb begin
        st_word = '0;
        st_be   = 4'b0000;
        case (i_size)
            SIZE_BYTE: begin
                st_word.bytes[lane] = i_wdata[7:0];
                st_be[lane]         = 1'b1;
            end
            SIZE_HALF: begin
                st_word.halves[lane[1]] = i_wdata[15:0];
                st_be = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_word = i_wdata;
                st_be   = 4'b1111;
            end
        endcase
    end

    // load lane select and extension
    assign ld_word = i_m_rdata;
    assign ld_byte = ld_word.bytes[lane];
    assign ld_half = ld_word.halves[lane[1]];

    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                ld_sign  = ld_byte[7] & ~i_unsigned;
                ld_value = {{(WORD_LEN-8){ld_sign}}, ld_byte};
            end
            SIZE_HALF: begin
                ld_sign  = ld_half[15] & ~i_unsigned;
                ld_value = {{(WORD_LEN-16){ld_sign}}, ld_half};
            end
            default: begin
                ld_sign  = 1'b0;       // full word, nothing to extend
                ld_value = ld_word;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state        <= LSU_IDLE;
            o_ack        <= 1'b0;
            o_misaligned <= 1'b0;
            o_m_req      <= 1'b0;
        end else begin
            case (state)
                LSU_IDLE: begin
                    if (i_req && misaligned) begin
                        o_ack        <= 1'b1;  // refuse, memory untouched
                        o_misaligned <= 1'b1;
                        state        <= LSU_ACK;
                    end else if (i_req) begin
                        o_m_req <= 1'b1;
                        state   <= LSU_MEM;
                    end
                end
                LSU_MEM: begin
                    if (i_m_ack) begin
                        o_m_req <= 1'b0;
                        o_ack   <= 1'b1;
                        state   <= LSU_ACK;
                    end
                end
                LSU_ACK: begin
                    // both handshakes back to zero before the next request
                    if (!i_req && !i_m_ack) begin
                        o_ack        <= 1'b0;
                        o_misaligned <= 1'b0;
                        state        <= LSU_IDLE;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == LSU_IDLE && i_req) begin
            o_m_we    <= i_write_en;
            o_m_be    <= st_be;
            o_m_addr  <= i_addr[ADDR_LEN-1:2];
            o_m_wdata <= st_word;
        end
        if (state == LSU_MEM && i_m_ack && !o_m_we) begin
            o_rdata <= ld_value;
        end
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import dmem_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    // master 0, load/store unit
    input  logic                     i_m0_req,
    input  logic                     i_m0_we,
    input  logic [3:0]               i_m0_be,
    input  logic [WORD_ADDR_LEN-1:0] i_m0_addr,
    input  logic [WORD_LEN-1:0]      i_m0_wdata,
    output logic                     o_m0_ack,
    output logic [WORD_LEN-1:0]      o_m0_rdata,
    // master 1, copy engine
    input  logic                     i_m1_req,
    input  logic                     i_m1_we,
    input  logic [3:0]               i_m1_be,
    input  logic [WORD_ADDR_LEN-1:0] i_m1_addr,
    input  logic [WORD_LEN-1:0]      i_m1_wdata,
    output logic                     o_m1_ack,
    output logic [WORD_LEN-1:0]      o_m1_rdata,
    // memory side
    output logic                     o_mem_en,
    output logic                     o_mem_we,
    output logic [3:0]               o_mem_be,
    output logic [WORD_ADDR_LEN-1:0] o_mem_addr,
    output logic [WORD_LEN-1:0]      o_mem_wdata,
    input  logic [WORD_LEN-1:0]      i_mem_rdata
);

    logic [2:0]          state;
    logic                last_served;  // also the current grant while busy
    logic                pick;
    logic                req_sel;
    logic [WORD_LEN-1:0] rdata_q;

    // on a tie the master not served last goes first
    assign pick    = (i_m0_req && i_m1_req) ? ~last_served : i_m1_req;
    assign req_sel = last_served ? i_m1_req : i_m0_req;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= ARB_IDLE;
            last_served <= 1'b1;  // so master 0 wins the first tie
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (i_m0_req || i_m1_req) begin
                        last_served <= pick;
                        state       <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS:  state <= ARB_CAPTURE;  // mem_en high here
                ARB_CAPTURE: state <= ARB_ACK;      // read word arrives
                ARB_ACK: begin
                    if (!req_sel) begin
                        state <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: state <= ARB_IDLE;
                default:     state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ARB_CAPTURE) begin
            rdata_q <= i_mem_rdata;
        end
    end

    // granted master's command, held by the master while req is high
    assign o_mem_en    = (state == ARB_ACCESS);
    assign o_mem_we    = last_served ? i_m1_we    : i_m0_we;
    assign o_mem_be    = last_served ? i_m1_be    : i_m0_be;
    assign o_mem_addr  = last_served ? i_m1_addr  : i_m0_addr;
    assign o_mem_wdata = last_served ? i_m1_wdata : i_m0_wdata;

    assign o_m0_ack   = (state == ARB_ACK) && !last_served;
    assign o_m1_ack   = (state == ARB_ACK) &&  last_served;
    assign o_m0_rdata = rdata_q;  // only meaningful while ack is high
    assign o_m1_rdata = rdata_q;

endmodule

//--- hw/data_memory.sv
`timescale 1ns/1ns

module data_memory import dmem_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  logic                     i_we,
    input  logic [3:0]               i_be,     // one bit per byte lane
    input  logic [WORD_ADDR_LEN-1:0] i_addr,   // word index
    input  logic [WORD_LEN-1:0]      i_wdata,
    output logic [WORD_LEN-1:0]      o_rdata
);

    logic [WORD_LEN-1:0] mem [MEM_WORDS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rdata <= '0;
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            // little endian, byte 0 holds 11
            mem[0] <= 32'h4433_2211;
        end else if (i_en) begin
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_be[b]) begin
                        mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end else begin
                o_rdata <= mem[i_addr];  // one cycle read latency
            end
        end
    end

endmodule

//--- hw/dmem_pkg.sv
package dmem_pkg;

    localparam int WORD_LEN      = 32;
    localparam int ADDR_LEN      = 10;   // byte address
    localparam int MEM_WORDS     = 256;  // 1024 bytes
    localparam int WORD_ADDR_LEN = 8;
    localparam int COPY_LEN_W    = 8;

    // access size codes
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // arbiter FSM
    localparam logic [2:0] ARB_IDLE    = 3'd0;
    localparam logic [2:0] ARB_ACCESS  = 3'd1;
    localparam logic [2:0] ARB_CAPTURE = 3'd2;
    localparam logic [2:0] ARB_ACK     = 3'd3;
    localparam logic [2:0] ARB_RELEASE = 3'd4;

    // load/store unit FSM
    localparam logic [1:0] LSU_IDLE = 2'd0;
    localparam logic [1:0] LSU_MEM  = 2'd1;
    localparam logic [1:0] LSU_ACK  = 2'd2;

    // copy engine FSM
    localparam logic [2:0] CPY_IDLE   = 3'd0;
    localparam logic [2:0] CPY_RD     = 3'd1;
    localparam logic [2:0] CPY_RD_REL = 3'd2;
    localparam logic [2:0] CPY_WR     = 3'd3;
    localparam logic [2:0] CPY_WR_REL = 3'd4;
    localparam logic [2:0] CPY_DONE   = 3'd5;

    // one memory word, seen as byte lanes or as half-word lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lane_word_u;

endpackage
